// ==== icache_settings.svh ====
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// address and data widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// address split, tag | index | offset
`define ICACHE_OFFSET_W 6
`define ICACHE_INDEX_W 7
`define ICACHE_TAG_W 19

// 64 byte line holds 16 words
`define ICACHE_WORDS_PER_LINE 16

// beats minus one, as sent on the memory request
`define ICACHE_BURST_LEN 15

// uncached window, top nibble 0xA
`define ICACHE_UNCACHED_MASK 32'hF000_0000
`define ICACHE_UNCACHED_BASE 32'hA000_0000

`endif

// ==== icache_addr_pkg.sv ====
`default_nettype none
`include "icache_settings.svh"

package icache_addr_pkg;

  // fields of a fetch address
  typedef logic [`ICACHE_TAG_W-1:0] line_tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] line_index_t;
  // word within a line, offset without the byte bits
  typedef logic [`ICACHE_OFFSET_W-3:0] word_sel_t;

  // msb first, adds up to the full address width
  typedef struct packed {
    line_tag_t   tag;
    line_index_t index;
    word_sel_t   word;
    logic [1:0]  byte_off;
  } fetch_fields_t;

  // raw view for window test and memory address
  // fields view for indexing the stores
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    fetch_fields_t             fields;
  } fetch_addr_u;

endpackage

`default_nettype wire

// ==== icache_bus_pkg.sv ====
`default_nettype none
`include "icache_settings.svh"

package icache_bus_pkg;

  // fetch stage to cache
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;
  } fetch_req_t;

  // cache to fetch stage
  // word at the word aligned fetch address
  typedef struct packed {
    logic [`ICACHE_WORD_W-1:0] data;
  } fetch_rsp_t;

  // read request to burst memory
  // len is beats minus one, 0 for a single beat
  typedef struct packed {
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic [7:0]                len;
  } mem_req_t;

  // one beat moves per edge with valid and rready high
  // request stays put until the last beat

endpackage

`default_nettype wire

// ==== icache_tag_store.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_tag_store (
  input  logic                         clk,
  input  logic                         rst,
  input  icache_addr_pkg::fetch_addr_u lookup_addr_i,
  input  logic                         tag_write_i,
  output logic                         hit_o
);
  import icache_addr_pkg::*;

  localparam int unsigned LINES = 1 << `ICACHE_INDEX_W;

  // one valid bit and one tag per line
  logic [LINES-1:0] valid_q;
  line_tag_t        tag_q [LINES];

  line_index_t line_idx;
  line_tag_t   line_tag;

  assign line_idx = lookup_addr_i.fields.index;
  assign line_tag = lookup_addr_i.fields.tag;

  // valid bits cleared on reset, set on refill end
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_write_i) begin
      valid_q[line_idx] <= 1'b1;
    end
  end

  // new tag overwrites old one, direct mapped eviction
  always_ff @(posedge clk) begin
    if (tag_write_i) begin
      tag_q[line_idx] <= line_tag;
    end
  end

  // combinational compare at the indexed line
  assign hit_o = valid_q[line_idx] && (tag_q[line_idx] == line_tag);

endmodule

`default_nettype wire

// ==== icache_data_store.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_data_store (
  input  logic                         clk,
  input  icache_addr_pkg::fetch_addr_u lookup_addr_i,
  input  logic                         word_we_i,
  input  icache_addr_pkg::word_sel_t   word_sel_i,
  input  logic [`ICACHE_WORD_W-1:0]    wdata_i,
  output logic [`ICACHE_WORD_W-1:0]    rdata_o
);
  import icache_addr_pkg::*;

  // all lines back to back, 128 x 16 words
  localparam int unsigned DEPTH = (1 << `ICACHE_INDEX_W) * `ICACHE_WORDS_PER_LINE;
  localparam int unsigned AW    = $clog2(DEPTH);

  logic [`ICACHE_WORD_W-1:0] mem_q [DEPTH];

  line_index_t   line_idx;
  logic [AW-1:0] waddr;
  logic [AW-1:0] raddr;

  assign line_idx = lookup_addr_i.fields.index;

  // refill word from beat counter
  assign waddr = {line_idx, word_sel_i};
  // lookup word from fetch address
  assign raddr = {line_idx, lookup_addr_i.fields.word};

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (word_we_i) begin
      mem_q[waddr] <= wdata_i;
    end
  end

  // async read, hit decided in the same cycle
  assign rdata_o = mem_q[raddr];

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_ctrl (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         fetch_req_valid_i,
  input  icache_bus_pkg::fetch_req_t   fetch_req_i,
  output logic                         fetch_req_ready_o,
  output logic                         fetch_rsp_valid_o,
  output icache_bus_pkg::fetch_rsp_t   fetch_rsp_o,
  output logic                         mem_req_valid_o,
  output icache_bus_pkg::mem_req_t     mem_req_o,
  input  logic                         mem_rready_i,
  input  logic [`ICACHE_WORD_W-1:0]    mem_rdata_i,
  output icache_addr_pkg::fetch_addr_u lookup_addr_o,
  input  logic                         hit_i,
  input  logic [`ICACHE_WORD_W-1:0]    rdata_i,
  output logic                         tag_write_o,
  output logic                         word_we_o,
  output icache_addr_pkg::word_sel_t   word_sel_o
);
  import icache_addr_pkg::*;
  import icache_bus_pkg::*;

  typedef enum logic [2:0] {
    st_reset,
    st_idle,
    st_lookup,
    st_refill,
    st_uncached
  } state_t;

  state_t      state_q;
  fetch_addr_u addr_q;
  word_sel_t   beat_q;
  logic        rsp_valid_q;
  fetch_rsp_t  rsp_q;
  logic        mem_valid_q;
  mem_req_t    mem_req_q;

  logic uncached;
  logic beat_fire;
  logic last_beat;

  // uncached window decoded on the raw view
  assign uncached  = (addr_q.raw & `ICACHE_UNCACHED_MASK) == `ICACHE_UNCACHED_BASE;
  assign beat_fire = mem_valid_q & mem_rready_i;
  assign last_beat = beat_q == word_sel_t'(`ICACHE_BURST_LEN);

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= st_reset;
      rsp_valid_q <= 1'b0;
      mem_valid_q <= 1'b0;
      beat_q      <= '0;
    end else begin
      // response is a single cycle pulse
      rsp_valid_q <= 1'b0;
      case (state_q)
        st_reset: state_q <= st_idle;
        st_idle: begin
          if (fetch_req_valid_i) begin
            state_q <= st_lookup;
          end
        end
        st_lookup: begin
          // window checked first, never looked up in the stores
          if (uncached) begin
            state_q     <= st_uncached;
            mem_valid_q <= 1'b1;
          end else if (hit_i) begin
            state_q     <= st_idle;
            rsp_valid_q <= 1'b1;
          end else begin
            state_q     <= st_refill;
            mem_valid_q <= 1'b1;
            beat_q      <= '0;
          end
        end
        st_refill: begin
          if (beat_fire) begin
            if (last_beat) begin
              // line complete, retry lookup which now hits
              state_q     <= st_lookup;
              mem_valid_q <= 1'b0;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        st_uncached: begin
          if (beat_fire) begin
            state_q     <= st_idle;
            mem_valid_q <= 1'b0;
            rsp_valid_q <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // address, request and response payload
  always_ff @(posedge clk) begin
    if (fetch_req_valid_i && fetch_req_ready_o) begin
      addr_q.raw <= fetch_req_i.addr;
    end
    if (state_q == st_lookup) begin
      rsp_q.data <= rdata_i;
      if (uncached) begin
        // exact word, single beat
        mem_req_q.addr <= {addr_q.raw[`ICACHE_ADDR_W-1:2], 2'b00};
        mem_req_q.len  <= 8'd0;
      end else begin
        // whole line from its first word
        mem_req_q.addr <= {addr_q.raw[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                           {`ICACHE_OFFSET_W{1'b0}}};
        mem_req_q.len  <= 8'(`ICACHE_BURST_LEN);
      end
    end
    // uncached beat goes to the response only
    if (state_q == st_uncached && beat_fire) begin
      rsp_q.data <= mem_rdata_i;
    end
  end

  assign fetch_req_ready_o = state_q == st_idle;
  assign fetch_rsp_valid_o = rsp_valid_q;
  assign fetch_rsp_o       = rsp_q;
  assign mem_req_valid_o   = mem_valid_q;
  assign mem_req_o         = mem_req_q;
  assign lookup_addr_o     = addr_q;

  // refill writes, tag on the last beat
  assign word_we_o   = (state_q == st_refill) && beat_fire;
  assign tag_write_o = (state_q == st_refill) && beat_fire && last_beat;
  assign word_sel_o  = beat_q;

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_req_valid_i,
  input  icache_bus_pkg::fetch_req_t fetch_req_i,
  output logic                       fetch_req_ready_o,
  output logic                       fetch_rsp_valid_o,
  output icache_bus_pkg::fetch_rsp_t fetch_rsp_o,
  output logic                       mem_req_valid_o,
  output icache_bus_pkg::mem_req_t   mem_req_o,
  input  logic                       mem_rready_i,
  input  logic [`ICACHE_WORD_W-1:0]  mem_rdata_i
);
  import icache_addr_pkg::*;

  // controller to stores
  fetch_addr_u               lookup_addr;
  logic                      hit;
  logic [`ICACHE_WORD_W-1:0] rdata;
  logic                      tag_write;
  logic                      word_we;
  word_sel_t                 word_sel;

  icache_ctrl u_ctrl (
    .clk               (clk),
    .rst               (rst),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_o         (mem_req_o),
    .mem_rready_i      (mem_rready_i),
    .mem_rdata_i       (mem_rdata_i),
    .lookup_addr_o     (lookup_addr),
    .hit_i             (hit),
    .rdata_i           (rdata),
    .tag_write_o       (tag_write),
    .word_we_o         (word_we),
    .word_sel_o        (word_sel)
  );

  icache_tag_store u_tag_store (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (lookup_addr),
    .tag_write_i   (tag_write),
    .hit_o         (hit)
  );

  // beat data written straight from memory
  icache_data_store u_data_store (
    .clk           (clk),
    .lookup_addr_i (lookup_addr),
    .word_we_i     (word_we),
    .word_sel_i    (word_sel),
    .wdata_i       (mem_rdata_i),
    .rdata_o       (rdata)
  );

endmodule

`default_nettype wire

// ==== icache_assert.sv ====
`default_nettype none

module icache_assert (
  input logic                     clk,
  input logic                     rst,
  input logic                     req_ready_i,
  input logic                     rsp_valid_i,
  input logic                     mem_valid_i,
  input icache_bus_pkg::mem_req_t mem_req_i
);

  // address and length held until the last beat
  a_mem_req_held: assert property (
    @(posedge clk) disable iff (rst)
      (mem_valid_i && $past(mem_valid_i)) |-> $stable(mem_req_i)
  ) else $error("memory request changed during a transfer");

  // response is a single cycle pulse
  a_rsp_pulse: assert property (
    @(posedge clk) disable iff (rst)
      rsp_valid_i |=> !rsp_valid_i
  ) else $error("fetch response valid held for two cycles");

  // blocking cache, no new fetch while memory is busy
  a_no_accept_busy: assert property (
    @(posedge clk) disable iff (rst)
      mem_valid_i |-> !req_ready_i
  ) else $error("fetch ready high during a memory transfer");

endmodule

bind icache_top icache_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .req_ready_i (fetch_req_ready_o),
  .rsp_valid_i (fetch_rsp_valid_o),
  .mem_valid_i (mem_req_valid_o),
  .mem_req_i   (mem_req_o)
);

`default_nettype wire

// ==== icache_tb.sv ====
`default_nettype none
`include "icache_settings.svh"

module icache_tb;
  import icache_bus_pkg::*;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 4;
  localparam int RAND_FETCHES = 40;
  // directed fetches plus the random run
  localparam int N_FETCHES    = 9 + RAND_FETCHES;
  // 16 beat refill at a quarter stall rate, with wide margin
  localparam int FETCH_CYCLES = 100;
  localparam int TIMEOUT      = (RESET_CYCLES + 10 + N_FETCHES * FETCH_CYCLES) * PERIOD;

  logic        clk;
  logic        rst;
  logic        fetch_req_valid_i;
  fetch_req_t  fetch_req_i;
  logic        fetch_req_ready_o;
  logic        fetch_rsp_valid_o;
  fetch_rsp_t  fetch_rsp_o;
  logic        mem_req_valid_o;
  mem_req_t    mem_req_o;
  logic        mem_rready_i;
  logic [31:0] mem_rdata_i;

  // expected words in fetch order
  logic [31:0] exp_q[$];
  string       cur_test;
  int          err_count;
  int          check_count;
  int          test_count;
  int          test_err_base;
  int          unc_issued;

  // memory model state
  logic        stall_en;
  logic        req_prev;
  int          cur_beats;
  int          last_beats;
  int          req_count;
  int          unc_served;
  mem_req_t    last_req;

  icache_top DUT (
    .clk               (clk),
    .rst               (rst),
    .fetch_req_valid_i (fetch_req_valid_i),
    .fetch_req_i       (fetch_req_i),
    .fetch_req_ready_o (fetch_req_ready_o),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_rsp_o       (fetch_rsp_o),
    .mem_req_valid_o   (mem_req_valid_o),
    .mem_req_o         (mem_req_o),
    .mem_rready_i      (mem_rready_i),
    .mem_rdata_i       (mem_rdata_i)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // backing memory content, word address xor a fixed pattern
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5A5A_5A5A;
  endfunction

  function automatic logic in_uncached(input logic [31:0] addr);
    return (addr & `ICACHE_UNCACHED_MASK) == `ICACHE_UNCACHED_BASE;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    err_count++;
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_count;
  endtask

  // one edge more so the negedge checker has run
  task automatic end_test();
    @(posedge clk);
    test_count++;
    $display("test %s done, %0d errors", cur_test, err_count - test_err_base);
  endtask

  // memory side, sampled and driven on the falling edge
  // a beat set up here moves on the next rising edge
  always @(negedge clk) begin
    logic [31:0] beat_addr;
    if (rst) begin
      req_prev     = 1'b0;
      cur_beats    = 0;
      mem_rready_i = 1'b0;
    end else begin
      if (mem_req_valid_o && !req_prev) begin
        req_count++;
        last_req = mem_req_o;
      end
      if (!mem_req_valid_o && req_prev) begin
        last_beats = cur_beats;
        cur_beats  = 0;
      end
      req_prev     = mem_req_valid_o;
      beat_addr    = mem_req_o.addr + 32'(cur_beats * 4);
      mem_rready_i = mem_req_valid_o && (!stall_en || (($urandom & 32'd3) != 0));
      // uncached words shift by the number of reads served
      if (in_uncached(mem_req_o.addr)) begin
        mem_rdata_i = mem_word(beat_addr) + 32'(unc_served);
      end else begin
        mem_rdata_i = mem_word(beat_addr);
      end
      if (mem_rready_i) begin
        cur_beats++;
        if (in_uncached(mem_req_o.addr)) begin
          unc_served++;
        end
      end
    end
  end

  // compare every response pulse against the oldest expected word
  always @(negedge clk) begin
    logic [31:0] want;
    if (!rst && fetch_rsp_valid_o) begin
      check_count++;
      if (exp_q.size() == 0) begin
        $display("a response arrived in test %s with no fetch outstanding", cur_test);
        err_count++;
      end else begin
        want = exp_q.pop_front();
        if (fetch_rsp_o.data !== want) begin
          report_mismatch("response", want, fetch_rsp_o.data);
        end
      end
    end
  end

  // latency counts edges from the accepting edge to the edge that takes the response
  task automatic fetch_word(input logic [31:0] addr, output int latency);
    @(negedge clk);
    fetch_req_valid_i = 1'b1;
    fetch_req_i.addr  = addr;
    // ready seen here means the next rising edge accepts
    while (fetch_req_ready_o !== 1'b1) begin
      @(negedge clk);
    end
    if (in_uncached(addr)) begin
      exp_q.push_back(mem_word(addr) + 32'(unc_issued));
      unc_issued++;
    end else begin
      exp_q.push_back(mem_word(addr));
    end
    latency = 1;
    @(negedge clk);
    fetch_req_valid_i = 1'b0;
    while (fetch_rsp_valid_o !== 1'b1) begin
      @(negedge clk);
      latency++;
    end
  endtask

  initial begin
    int          lat;
    int          base;
    logic [31:0] a;
    void'($urandom(32'hca63));
    rst               = 1'b1;
    fetch_req_valid_i = 1'b0;
    fetch_req_i       = '0;
    mem_rready_i      = 1'b0;
    mem_rdata_i       = '0;
    stall_en          = 1'b0;
    err_count         = 0;
    check_count       = 0;
    test_count        = 0;
    unc_issued        = 0;
    req_count         = 0;
    unc_served        = 0;
    last_beats        = 0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    start_test("reset");
    if (mem_req_valid_o !== 1'b0) begin
      $display("memory request is active right after reset");
      err_count++;
    end
    if (fetch_rsp_valid_o !== 1'b0) begin
      $display("fetch response is active right after reset");
      err_count++;
    end
    lat = 0;
    while (fetch_req_ready_o !== 1'b1 && lat < 4) begin
      @(negedge clk);
      lat++;
    end
    if (fetch_req_ready_o !== 1'b1) begin
      $display("fetch ready never rose after reset");
      err_count++;
    end
    end_test();

    start_test("cold_miss");
    base = req_count;
    fetch_word(32'h0000_0848, lat);
    if (req_count != base + 1) begin
      report_mismatch("request count", base + 1, req_count);
    end
    if (last_req.addr !== 32'h0000_0840) begin
      report_mismatch("request address", 32'h0000_0840, last_req.addr);
    end
    if (last_req.len !== 8'd15) begin
      report_mismatch("burst length", 32'd15, 32'(last_req.len));
    end
    if (last_beats != 16) begin
      report_mismatch("beats", 32'd16, last_beats);
    end
    end_test();

    // other word of the line just filled
    start_test("hit");
    base = req_count;
    fetch_word(32'h0000_0870, lat);
    if (lat != 2) begin
      report_mismatch("latency", 32'd2, lat);
    end
    if (req_count != base) begin
      report_mismatch("request count", base, req_count);
    end
    end_test();

    // same index, tags 9 and 10
    start_test("eviction");
    for (int i = 0; i < 4; i++) begin
      base = req_count;
      a    = ((i % 2) == 0) ? 32'h0001_2340 : 32'h0001_4344;
      fetch_word(a, lat);
      if (req_count != base + 1) begin
        report_mismatch("refill count", base + 1, req_count);
      end
    end
    end_test();

    // unaligned on purpose, low bits dropped on the bus
    start_test("uncached");
    for (int i = 0; i < 3; i++) begin
      base = req_count;
      fetch_word(32'hA000_0106, lat);
      if (req_count != base + 1) begin
        report_mismatch("request count", base + 1, req_count);
      end
      if (last_req.addr !== 32'hA000_0104) begin
        report_mismatch("request address", 32'hA000_0104, last_req.addr);
      end
      if (last_req.len !== 8'd0) begin
        report_mismatch("burst length", 32'd0, 32'(last_req.len));
      end
    end
    end_test();

    // four tags per index in range, so hits and evictions mix
    start_test("random");
    stall_en = 1'b1;
    for (int i = 0; i < RAND_FETCHES; i++) begin
      a = $urandom & 32'h0000_7FFF;
      fetch_word(a, lat);
    end
    stall_en = 1'b0;
    end_test();

    @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived", exp_q.size());
      err_count++;
    end
    $display("tests %0d, responses checked %0d, errors %0d",
             test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog, worst case of all fetches
  initial begin
    #(TIMEOUT);
    $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
icache_addr_pkg.sv
icache_bus_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_ctrl.sv
icache_top.sv
icache_assert.sv
icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module icache_tb -f files.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null &&
echo "simulation passed" && exit 0 ||
{ echo "simulation failed"; exit 1; }
